//--- all.f
+incdir+.
thumb_isa_pkg.sv
thumb_core_pkg.sv
thumb_fetch.sv
thumb_decode.sv
thumb_regfile.sv
thumb_execute.sv
thumb_mem_wb.sv
thumb_core.sv
tb_thumb_assertions.sv
tb_thumb_core.sv

//--- tb_thumb_assertions.sv
`timescale 1ns/1ps

module tb_thumb_assertions (
	input logic                       clk,
	input logic                       rst,
	input logic                       mem_we,
	input thumb_core_pkg::addr_t      mem_addr,
	input thumb_core_pkg::mem_size_e  mem_size,
	input thumb_core_pkg::seq_state_e state
);

	int   error_count = 0;
	logic aligned;

	// Word needs both low bits clear, halfword only bit 0
	assign aligned = (mem_size == thumb_core_pkg::SIZE_BYTE) ||
		(mem_size == thumb_core_pkg::SIZE_HALF && !mem_addr[0]) ||
		(mem_addr[1:0] == 2'b00);

	we_single: assert property (@(posedge clk) disable iff (rst) mem_we |=> !mem_we)
		else begin
			$error("mem_we high in two consecutive cycles");
			error_count++;
		end

	// Synchronous reset takes effect at the first edge
	we_reset: assert property (@(posedge clk) rst |=> !mem_we)
		else begin
			$error("mem_we high while in reset");
			error_count++;
		end

	store_align: assert property (@(posedge clk) disable iff (rst) mem_we |-> aligned)
		else begin
			$error("store address not aligned to its size");
			error_count++;
		end

	state_moves: assert property (@(posedge clk) disable iff (rst) 1'b1 |=> state != $past(state))
		else begin
			$error("sequencer held a state for two cycles");
			error_count++;
		end

endmodule

//--- tb_thumb_core.sv
`timescale 1ns/1ps
`include "thumb_config.svh"

module tb_thumb_core;

	localparam int NUM_INSTR  = 60;
	localparam int NUM_CYCLES = 5 * NUM_INSTR + 5;

	logic                      clk;
	logic                      rst;
	thumb_core_pkg::addr_t     prog_addr;
	thumb_core_pkg::word_t     prog_data;
	thumb_core_pkg::addr_t     mem_addr;
	thumb_core_pkg::word_t     mem_wdata;
	thumb_core_pkg::mem_size_e mem_size;
	logic                      mem_we;
	thumb_core_pkg::word_t     mem_rdata;

	integer                    seed;
	thumb_isa_pkg::instr_t     prog [128];       // Halfword view of the program
	thumb_core_pkg::word_t     pmem [64];
	thumb_core_pkg::word_t     dmem [64];        // Memory seen by the DUT
	thumb_core_pkg::word_t     model_mem [64];
	thumb_core_pkg::word_t     model_regs [`THUMB_NREGS];

	thumb_core dut_i (
		.clk(clk), .rst(rst), .prog_addr(prog_addr), .prog_data(prog_data),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_size(mem_size),
		.mem_we(mem_we), .mem_rdata(mem_rdata)
	);

	bind thumb_core tb_thumb_assertions assertions_i (
		.clk(clk), .rst(rst), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_size(mem_size), .state(state)
	);

	always #20 clk = ~clk;

	// Both memories answer in the same cycle
	assign prog_data = pmem[prog_addr[7:2]];
	assign mem_rdata = dmem[mem_addr[7:2]];

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic thumb_core_pkg::word_t merge_store(input thumb_core_pkg::word_t old,
			input thumb_core_pkg::word_t data, input thumb_core_pkg::addr_t addr,
			input logic [1:0] size);
		thumb_core_pkg::word_t merged;
		merged = old;
		case (size)
			2'd0:    merged[addr[1:0] * 8 +: 8] = data[7:0];
			2'd1:    merged[addr[1] * 16 +: 16] = data[15:0];
			default: merged = data;
		endcase
		return merged;
	endfunction

	function automatic thumb_core_pkg::word_t load_lane(input thumb_core_pkg::word_t w,
			input thumb_core_pkg::addr_t addr, input logic [1:0] size);
		case (size)
			2'd0:    return {24'h0, w[addr[1:0] * 8 +: 8]};
			2'd1:    return {16'h0, w[addr[1] * 16 +: 16]};
			default: return w;
		endcase
	endfunction

	// Steps model registers and memory through one instruction
	function automatic void ref_step(input thumb_isa_pkg::instr_t ins, output logic acc,
			output logic st, output thumb_core_pkg::addr_t addr,
			output thumb_core_pkg::word_t data, output logic [1:0] size);
		thumb_core_pkg::word_t lo;   // Register in bits 5:3
		thumb_core_pkg::word_t dn;   // Register in bits 2:0
		thumb_core_pkg::word_t opb;
		thumb_core_pkg::word_t res;
		logic [4:0]            imm5;
		logic                  wr;
		lo   = model_regs[ins[5:3]];
		dn   = model_regs[ins[2:0]];
		imm5 = ins[10:6];
		acc  = 1'b0;
		st   = 1'b0;
		addr = '0;
		data = '0;
		size = 2'd2;
		res  = '0;
		wr   = 1'b1;
		case (ins[15:11])
			5'b00000: res = lo << imm5;
			5'b00001: res = lo >> imm5;
			5'b00010: res = $signed(lo) >>> imm5;
			5'b00011: begin
				opb = ins[10] ? 32'(ins[8:6]) : model_regs[ins[8:6]]; // imm3 or Rm
				res = ins[9] ? lo - opb : lo + opb;
			end
			5'b00100: res = 32'(ins[7:0]);
			5'b00110: res = model_regs[ins[10:8]] + 32'(ins[7:0]);
			5'b00111: res = model_regs[ins[10:8]] - 32'(ins[7:0]);
			5'b01000: begin
				case (ins[9:6])
					4'b0000: res = dn & lo;
					4'b0001: res = dn ^ lo;
					4'b1100: res = dn | lo;
					4'b1101: res = dn * lo;
					4'b1110: res = dn & ~lo;
					default: res = ~lo;
				endcase
			end
			default: begin
				acc  = 1'b1; // Loads and stores, bit 11 set for loads
				size = ins[15] ? 2'd1 : (ins[12] ? 2'd0 : 2'd2);
				addr = lo + (32'(imm5) << size);
				st   = !ins[11];
				data = dn;
				wr   = !st;
				if (st) begin
					model_mem[addr[7:2]] = merge_store(model_mem[addr[7:2]], dn, addr, size);
				end else begin
					res = load_lane(model_mem[addr[7:2]], addr, size);
				end
			end
		endcase
		if (wr) begin
			if (ins[15:11] == 5'b00100 || ins[15:12] == 4'b0011) begin
				model_regs[ins[10:8]] = res;
			end else begin
				model_regs[ins[2:0]] = res;
			end
		end
	endfunction

	task automatic build_program();
		int         idx;
		int         op;
		int         loads;
		int         narrow;
		logic [2:0] rd;
		logic [4:0] opc;
		idx    = 0;
		loads  = 0;
		narrow = 0;
		for (int r = 0; r < 8; r++) begin
			prog[idx] = {5'b00100, 3'(r), (r == 7) ? 8'h20 : 8'(pick(256))}; // r7 is the base
			idx++;
		end
		while (idx < NUM_INSTR) begin
			rd = 3'(pick(7)); // Never r7
			case (pick(10))
				0: prog[idx] = {6'b000110, 1'(pick(2)), 3'(pick(8)), 3'(pick(8)), rd};
				1: prog[idx] = {6'b000111, 1'(pick(2)), 3'(pick(8)), 3'(pick(8)), rd};
				2: prog[idx] = {4'b0011, 1'(pick(2)), rd, 8'(pick(256))};
				3: prog[idx] = {3'b000, 2'(pick(3)), 5'(1 + pick(31)), 3'(pick(8)), rd};
				4, 5: begin
					op        = pick(6);
					prog[idx] = {6'b010000, (op < 2) ? 4'(op) : 4'(op + 10), 3'(pick(8)), rd};
				end
				6: prog[idx] = {5'b01100, 5'(pick(32)), 3'd7, 3'(pick(8))};
				7: begin
					opc       = narrow[0] ? 5'b10000 : 5'b01110; // STRH or STRB
					prog[idx] = {opc, 5'(pick(32)), 3'd7, 3'(pick(8))};
					narrow++;
				end
				8: begin
					if (idx < NUM_INSTR - 1) begin
						opc = (loads % 3 == 0) ? 5'b01101 : (loads % 3 == 1) ? 5'b01111 : 5'b10001;
						prog[idx] = {opc, 5'(pick(32)), 3'd7, rd};
						idx++;
						prog[idx] = {5'b01100, 5'(pick(32)), 3'd7, rd}; // Loaded value back out
						loads++;
					end else begin
						prog[idx] = {5'b00100, rd, 8'(pick(256))};
					end
				end
				default: prog[idx] = {5'b00100, rd, 8'(pick(256))};
			endcase
			idx++;
		end
		for (int i = NUM_INSTR; i < 128; i++) begin
			prog[i] = {5'b10110, 11'(i)}; // Undefined, acts as no-op
		end
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	// Data memory writes only the selected lanes
	always @(negedge clk) begin
		if (mem_we === 1'b1) begin
			dmem[mem_addr[7:2]] <= merge_store(dmem[mem_addr[7:2]], mem_wdata, mem_addr, mem_size);
		end
	end

	initial begin
		seed = 32'h5b16_9a30;
		clk  = 1'b0;
		rst  = 1'b1;
		build_program();
		for (int i = 0; i < 64; i++) begin
			pmem[i]      = {prog[2 * i + 1], prog[2 * i]};
			dmem[i]      = (32'(i) * 32'h0101_0101) ^ 32'ha5c3_1e69;
			model_mem[i] = dmem[i];
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

	initial begin
		int                    waited;
		int                    k;
		logic                  acc;
		logic                  st;
		logic [1:0]            size;
		thumb_core_pkg::addr_t addr;
		thumb_core_pkg::word_t data;
		thumb_core_pkg::word_t mask;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > 20) begin
				fail_run("reset was never released");
			end
		end while (rst !== 1'b0);
		// Cycle c counts from the idle cycle after release
		for (int c = 1; c <= NUM_CYCLES; c++) begin
			@(negedge clk);
			if (dut_i.assertions_i.error_count != 0) begin
				fail_run("a bound assertion on the core failed");
			end
			check_value("prog_addr", prog_addr, (2 * ((c + 3) / 5)) & ~32'h3);
			st = 1'b0;
			if (c % 5 == 4 && (c - 4) / 5 < NUM_INSTR) begin
				k = (c - 4) / 5;
				ref_step(prog[k], acc, st, addr, data, size);
				if (acc) begin
					check_value("mem_addr", mem_addr, addr);
					check_value("mem_size", 32'(mem_size), 32'(size));
				end
			end
			check_value("mem_we", 32'(mem_we), 32'(st));
			if (st) begin
				mask = (size == 2'd0) ? 32'hff : (size == 2'd1) ? 32'hffff : 32'hffff_ffff;
				check_value("mem_wdata", mem_wdata & mask, data & mask);
			end
		end
		@(posedge clk);
		for (int r = 0; r < `THUMB_NREGS; r++) begin
			check_value($sformatf("r%0d", r), dut_i.regfile_i.regs[r], model_regs[r]);
		end
		if (dut_i.assertions_i.error_count != 0) begin
			fail_run("a bound assertion on the core failed");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

//--- thumb_config.svh
`ifndef THUMB_CONFIG_SVH
`define THUMB_CONFIG_SVH

// Datapath word width
`define THUMB_XLEN 32

// Byte address width on both memory ports
`define THUMB_ALEN 32

// One 16-bit Thumb instruction
`define THUMB_ILEN 16

// Low registers r0 to r7 only
`define THUMB_NREGS 8

`endif

//--- thumb_core.sv
`timescale 1ns/1ps

module thumb_core (
	input  logic                      clk,
	input  logic                      rst,
	output thumb_core_pkg::addr_t     prog_addr,
	input  thumb_core_pkg::word_t     prog_data,
	output thumb_core_pkg::addr_t     mem_addr,
	output thumb_core_pkg::word_t     mem_wdata,
	output thumb_core_pkg::mem_size_e mem_size,
	output logic                      mem_we,
	input  thumb_core_pkg::word_t     mem_rdata
);

	thumb_core_pkg::seq_state_e state, state_next;
	logic                       fetch_en, dec_en, exec_en, mem_en, wb_en;
	thumb_isa_pkg::instr_t      instr;
	thumb_isa_pkg::reg_idx_t    rs_a, rs_b, rd, wr_idx;
	thumb_isa_pkg::imm_t        imm;
	thumb_core_pkg::alu_op_e    alu_op;
	thumb_core_pkg::mem_size_e  size;
	logic                       use_imm, reg_we, mem_store, mem_load, wr_en;
	thumb_core_pkg::word_t      rd_a, rd_b, result, store_data, wr_data;

	// Five states per instruction, idle only once after reset
	always_comb begin
		case (state)
			thumb_core_pkg::ST_IDLE:   state_next = thumb_core_pkg::ST_FETCH;
			thumb_core_pkg::ST_FETCH:  state_next = thumb_core_pkg::ST_DECODE;
			thumb_core_pkg::ST_DECODE: state_next = thumb_core_pkg::ST_EXEC;
			thumb_core_pkg::ST_EXEC:   state_next = thumb_core_pkg::ST_MEM;
			thumb_core_pkg::ST_MEM:    state_next = thumb_core_pkg::ST_WB;
			thumb_core_pkg::ST_WB:     state_next = thumb_core_pkg::ST_FETCH;
			default:                   state_next = thumb_core_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= thumb_core_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// One-hot stage strobes
	assign fetch_en = (state == thumb_core_pkg::ST_FETCH);
	assign dec_en   = (state == thumb_core_pkg::ST_DECODE);
	assign exec_en  = (state == thumb_core_pkg::ST_EXEC);
	assign mem_en   = (state == thumb_core_pkg::ST_MEM);
	assign wb_en    = (state == thumb_core_pkg::ST_WB);

	thumb_fetch fetch_i (
		.clk(clk), .rst(rst), .fetch_en(fetch_en),
		.prog_addr(prog_addr), .prog_data(prog_data), .instr(instr)
	);

	thumb_decode decode_i (
		.clk(clk), .rst(rst), .dec_en(dec_en), .instr(instr),
		.rs_a(rs_a), .rs_b(rs_b), .rd(rd), .imm(imm), .alu_op(alu_op),
		.use_imm(use_imm), .reg_we(reg_we), .mem_store(mem_store),
		.mem_load(mem_load), .size(size)
	);

	thumb_regfile regfile_i (
		.clk(clk), .rs_a(rs_a), .rs_b(rs_b), .rd_a(rd_a), .rd_b(rd_b),
		.wr_idx(wr_idx), .wr_data(wr_data), .wr_en(wr_en)
	);

	thumb_execute execute_i (
		.clk(clk), .exec_en(exec_en), .op_a(rd_a), .op_b(rd_b), .imm(imm),
		.use_imm(use_imm), .alu_op(alu_op), .result(result), .store_data(store_data)
	);

	thumb_mem_wb mem_wb_i (
		.clk(clk), .mem_en(mem_en), .wb_en(wb_en), .result(result),
		.store_data(store_data), .rd(rd), .reg_we(reg_we), .mem_store(mem_store),
		.mem_load(mem_load), .size(size), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_size(mem_size), .mem_we(mem_we), .mem_rdata(mem_rdata),
		.wr_idx(wr_idx), .wr_data(wr_data), .wr_en(wr_en)
	);

endmodule

//--- thumb_core_pkg.sv
`include "thumb_config.svh"

package thumb_core_pkg;

	typedef logic [`THUMB_XLEN-1:0] word_t;   // Register and bus data
	typedef logic [`THUMB_ALEN-1:0] addr_t;   // Byte address

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_EOR,
		ALU_ORR,
		ALU_BIC,
		ALU_MVN,
		ALU_MOV,
		ALU_LSL,
		ALU_LSR,
		ALU_ASR,
		ALU_MUL
	} alu_op_e;

	// Same encoding as the RAM size input of the MCU
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	typedef enum logic {
		WB_ALU,
		WB_MEM
	} wb_sel_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_EXEC,
		ST_MEM,
		ST_WB
	} seq_state_e;

endpackage

//--- thumb_decode.sv
`timescale 1ns/1ps

module thumb_decode (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       dec_en,
	input  thumb_isa_pkg::instr_t      instr,
	output thumb_isa_pkg::reg_idx_t    rs_a,
	output thumb_isa_pkg::reg_idx_t    rs_b,
	output thumb_isa_pkg::reg_idx_t    rd,
	output thumb_isa_pkg::imm_t        imm,
	output thumb_core_pkg::alu_op_e    alu_op,
	output logic                       use_imm,
	output logic                       reg_we,
	output logic                       mem_store,
	output logic                       mem_load,
	output thumb_core_pkg::mem_size_e  size
);

	thumb_isa_pkg::cmd_e       cmd;
	thumb_isa_pkg::reg_idx_t   rs_a_c, rs_b_c, rd_c;
	thumb_isa_pkg::imm_t       imm_c;
	thumb_core_pkg::alu_op_e   alu_op_c;
	thumb_core_pkg::mem_size_e size_c;
	logic                      use_imm_c, reg_we_c, store_c, load_c;

	// Instruction class from the top opcode bits
	always_comb begin
		cmd = thumb_isa_pkg::CMD_UNDEF;
		case (instr[15:11])
			5'b00000: cmd = thumb_isa_pkg::CMD_LSL_I5;
			5'b00001: cmd = thumb_isa_pkg::CMD_LSR_I5;
			5'b00010: cmd = thumb_isa_pkg::CMD_ASR_I5;
			5'b00011: begin
				case (instr[10:9])
					2'b00:   cmd = thumb_isa_pkg::CMD_ADD_REG;
					2'b01:   cmd = thumb_isa_pkg::CMD_SUB_REG;
					2'b10:   cmd = thumb_isa_pkg::CMD_ADD_I3;
					default: cmd = thumb_isa_pkg::CMD_SUB_I3;
				endcase
			end
			5'b00100: cmd = thumb_isa_pkg::CMD_MOV_I8;
			5'b00110: cmd = thumb_isa_pkg::CMD_ADD_I8;
			5'b00111: cmd = thumb_isa_pkg::CMD_SUB_I8;
			5'b01000: begin
				if (!instr[10]) begin // Data processing group only
					case (instr[9:6])
						4'b0000: cmd = thumb_isa_pkg::CMD_AND;
						4'b0001: cmd = thumb_isa_pkg::CMD_EOR;
						4'b1100: cmd = thumb_isa_pkg::CMD_ORR;
						4'b1101: cmd = thumb_isa_pkg::CMD_MUL;
						4'b1110: cmd = thumb_isa_pkg::CMD_BIC;
						4'b1111: cmd = thumb_isa_pkg::CMD_MVN;
						default: cmd = thumb_isa_pkg::CMD_UNDEF; // Flag users, reg shifts
					endcase
				end
			end
			5'b01100: cmd = thumb_isa_pkg::CMD_STR;
			5'b01101: cmd = thumb_isa_pkg::CMD_LDR;
			5'b01110: cmd = thumb_isa_pkg::CMD_STRB;
			5'b01111: cmd = thumb_isa_pkg::CMD_LDRB;
			5'b10000: cmd = thumb_isa_pkg::CMD_STRH;
			5'b10001: cmd = thumb_isa_pkg::CMD_LDRH;
			default:  cmd = thumb_isa_pkg::CMD_UNDEF;
		endcase
	end

	// Operand fields and control per command
	always_comb begin
		rs_a_c    = instr[5:3];  // Rn or Rm
		rs_b_c    = instr[8:6];  // Rm of the three-register form
		rd_c      = instr[2:0];
		imm_c     = '0;
		alu_op_c  = thumb_core_pkg::ALU_ADD;
		use_imm_c = 1'b1;
		reg_we_c  = 1'b1;
		store_c   = 1'b0;
		load_c    = 1'b0;
		size_c    = thumb_core_pkg::SIZE_WORD;
		case (cmd)
			thumb_isa_pkg::CMD_LSL_I5, thumb_isa_pkg::CMD_LSR_I5,
			thumb_isa_pkg::CMD_ASR_I5: begin
				imm_c = thumb_isa_pkg::imm_t'(instr[10:6]);
				if (cmd == thumb_isa_pkg::CMD_LSL_I5) begin
					alu_op_c = thumb_core_pkg::ALU_LSL;
				end else if (cmd == thumb_isa_pkg::CMD_LSR_I5) begin
					alu_op_c = thumb_core_pkg::ALU_LSR;
				end else begin
					alu_op_c = thumb_core_pkg::ALU_ASR;
				end
			end
			thumb_isa_pkg::CMD_ADD_REG: use_imm_c = 1'b0;
			thumb_isa_pkg::CMD_SUB_REG: begin
				alu_op_c  = thumb_core_pkg::ALU_SUB;
				use_imm_c = 1'b0;
			end
			thumb_isa_pkg::CMD_ADD_I3: imm_c = thumb_isa_pkg::imm_t'(instr[8:6]);
			thumb_isa_pkg::CMD_SUB_I3: begin
				imm_c    = thumb_isa_pkg::imm_t'(instr[8:6]);
				alu_op_c = thumb_core_pkg::ALU_SUB;
			end
			thumb_isa_pkg::CMD_MOV_I8: begin
				rd_c     = instr[10:8];
				imm_c    = thumb_isa_pkg::imm_t'(instr[7:0]);
				alu_op_c = thumb_core_pkg::ALU_MOV;
			end
			thumb_isa_pkg::CMD_ADD_I8, thumb_isa_pkg::CMD_SUB_I8: begin
				rs_a_c = instr[10:8]; // Rdn
				rd_c   = instr[10:8];
				imm_c  = thumb_isa_pkg::imm_t'(instr[7:0]);
				if (cmd == thumb_isa_pkg::CMD_SUB_I8) begin
					alu_op_c = thumb_core_pkg::ALU_SUB;
				end
			end
			thumb_isa_pkg::CMD_AND, thumb_isa_pkg::CMD_EOR, thumb_isa_pkg::CMD_ORR,
			thumb_isa_pkg::CMD_MUL, thumb_isa_pkg::CMD_BIC, thumb_isa_pkg::CMD_MVN: begin
				rs_a_c    = instr[2:0]; // Rdn
				rs_b_c    = instr[5:3]; // Rm
				use_imm_c = 1'b0;
				case (cmd)
					thumb_isa_pkg::CMD_AND: alu_op_c = thumb_core_pkg::ALU_AND;
					thumb_isa_pkg::CMD_EOR: alu_op_c = thumb_core_pkg::ALU_EOR;
					thumb_isa_pkg::CMD_ORR: alu_op_c = thumb_core_pkg::ALU_ORR;
					thumb_isa_pkg::CMD_MUL: alu_op_c = thumb_core_pkg::ALU_MUL;
					thumb_isa_pkg::CMD_BIC: alu_op_c = thumb_core_pkg::ALU_BIC;
					default:                alu_op_c = thumb_core_pkg::ALU_MVN;
				endcase
			end
			thumb_isa_pkg::CMD_STR, thumb_isa_pkg::CMD_LDR: begin
				imm_c    = thumb_isa_pkg::imm_t'({instr[10:6], 2'b00}); // Word scaled
				rs_b_c   = instr[2:0]; // Rt as store data
				store_c  = (cmd == thumb_isa_pkg::CMD_STR);
				load_c   = (cmd == thumb_isa_pkg::CMD_LDR);
				reg_we_c = load_c;
			end
			thumb_isa_pkg::CMD_STRH, thumb_isa_pkg::CMD_LDRH: begin
				imm_c    = thumb_isa_pkg::imm_t'({instr[10:6], 1'b0}); // Halfword scaled
				rs_b_c   = instr[2:0];
				size_c   = thumb_core_pkg::SIZE_HALF;
				store_c  = (cmd == thumb_isa_pkg::CMD_STRH);
				load_c   = (cmd == thumb_isa_pkg::CMD_LDRH);
				reg_we_c = load_c;
			end
			thumb_isa_pkg::CMD_STRB, thumb_isa_pkg::CMD_LDRB: begin
				imm_c    = thumb_isa_pkg::imm_t'(instr[10:6]);
				rs_b_c   = instr[2:0];
				size_c   = thumb_core_pkg::SIZE_BYTE;
				store_c  = (cmd == thumb_isa_pkg::CMD_STRB);
				load_c   = (cmd == thumb_isa_pkg::CMD_LDRB);
				reg_we_c = load_c;
			end
			default: reg_we_c = 1'b0; // Undefined acts as a no-op
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_we    <= 1'b0;
			mem_store <= 1'b0;
			mem_load  <= 1'b0;
		end else if (dec_en) begin
			reg_we    <= reg_we_c;
			mem_store <= store_c;
			mem_load  <= load_c;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_en) begin
			rs_a    <= rs_a_c;
			rs_b    <= rs_b_c;
			rd      <= rd_c;
			imm     <= imm_c;
			alu_op  <= alu_op_c;
			use_imm <= use_imm_c;
			size    <= size_c;
		end
	end

endmodule

//--- thumb_execute.sv
`timescale 1ns/1ps

module thumb_execute (
	input  logic                    clk,
	input  logic                    exec_en,
	input  thumb_core_pkg::word_t   op_a,
	input  thumb_core_pkg::word_t   op_b,
	input  thumb_isa_pkg::imm_t     imm,
	input  logic                    use_imm,
	input  thumb_core_pkg::alu_op_e alu_op,
	output thumb_core_pkg::word_t   result,
	output thumb_core_pkg::word_t   store_data
);

	thumb_core_pkg::word_t op2;
	thumb_core_pkg::word_t alu_out;
	logic [4:0]            shamt;

	assign op2   = use_imm ? imm : op_b;
	assign shamt = op2[4:0]; // Shift amount from low five bits

	always_comb begin
		case (alu_op)
			thumb_core_pkg::ALU_ADD: alu_out = op_a + op2;
			thumb_core_pkg::ALU_SUB: alu_out = op_a - op2;
			thumb_core_pkg::ALU_AND: alu_out = op_a & op2;
			thumb_core_pkg::ALU_EOR: alu_out = op_a ^ op2;
			thumb_core_pkg::ALU_ORR: alu_out = op_a | op2;
			thumb_core_pkg::ALU_BIC: alu_out = op_a & ~op2;
			thumb_core_pkg::ALU_MVN: alu_out = ~op2;
			thumb_core_pkg::ALU_MOV: alu_out = op2;
			// Shifts take Rm on port A and the imm5 amount
			thumb_core_pkg::ALU_LSL: alu_out = op_a << shamt;
			thumb_core_pkg::ALU_LSR: alu_out = op_a >> shamt;
			thumb_core_pkg::ALU_ASR: alu_out = $signed(op_a) >>> shamt;
			thumb_core_pkg::ALU_MUL: alu_out = op_a * op2; // Low 32 bits kept
			default:                 alu_out = op_a;
		endcase
	end

	// EX to MEM register
	always_ff @(posedge clk) begin
		if (exec_en) begin
			result     <= alu_out;
			store_data <= op_b; // Rt for stores
		end
	end

endmodule

//--- thumb_fetch.sv
`timescale 1ns/1ps

module thumb_fetch (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  fetch_en,
	output thumb_core_pkg::addr_t prog_addr,
	input  thumb_core_pkg::word_t prog_data,
	output thumb_isa_pkg::instr_t instr
);

	thumb_core_pkg::addr_t pc;
	thumb_isa_pkg::instr_t half_sel;

	// Program memory is word wide, two instructions per word
	assign prog_addr = {pc[$bits(pc)-1:2], 2'b00};

	// Little-endian halfword pick
	always_comb begin
		if (pc[1]) begin
			half_sel = prog_data[31:16]; // Upper halfword
		end else begin
			half_sel = prog_data[15:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (fetch_en) begin
			pc <= pc + 2; // Only 16-bit instructions, no branches
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_en) begin
			instr <= half_sel;
		end
	end

endmodule

//--- thumb_isa_pkg.sv
`include "thumb_config.svh"

package thumb_isa_pkg;

	typedef logic [`THUMB_ILEN-1:0] instr_t;               // One halfword instruction
	typedef logic [$clog2(`THUMB_NREGS)-1:0] reg_idx_t;    // r0 to r7
	typedef logic [`THUMB_XLEN-1:0] imm_t;                 // Zero-extended immediate

	// Supported commands, everything else decodes to CMD_UNDEF
	typedef enum logic [4:0] {
		CMD_MOV_I8,   // 00100 Rd imm8
		CMD_ADD_REG,  // 0001100 Rm Rn Rd
		CMD_SUB_REG,  // 0001101 Rm Rn Rd
		CMD_ADD_I3,   // 0001110 imm3 Rn Rd
		CMD_SUB_I3,   // 0001111 imm3 Rn Rd
		CMD_ADD_I8,   // 00110 Rdn imm8
		CMD_SUB_I8,   // 00111 Rdn imm8
		CMD_LSL_I5,   // 00000 imm5 Rm Rd
		CMD_LSR_I5,   // 00001 imm5 Rm Rd
		CMD_ASR_I5,   // 00010 imm5 Rm Rd
		CMD_AND,      // 0100000000 Rm Rdn
		CMD_EOR,      // 0100000001 Rm Rdn
		CMD_ORR,      // 0100001100 Rm Rdn
		CMD_MUL,      // 0100001101 Rn Rdm
		CMD_BIC,      // 0100001110 Rm Rdn
		CMD_MVN,      // 0100001111 Rm Rd
		CMD_STR,      // 01100 imm5 Rn Rt
		CMD_LDR,      // 01101 imm5 Rn Rt
		CMD_STRB,     // 01110 imm5 Rn Rt
		CMD_LDRB,     // 01111 imm5 Rn Rt
		CMD_STRH,     // 10000 imm5 Rn Rt
		CMD_LDRH,     // 10001 imm5 Rn Rt
		CMD_UNDEF
	} cmd_e;

	// Field positions shared by most 16-bit formats:
	// bits 2:0 hold Rd or Rt, bits 5:3 hold Rn or Rm,
	// bits 8:6 hold Rm or imm3, bits 10:6 hold imm5,
	// bits 10:8 hold Rd of the imm8 forms.

endpackage

//--- thumb_mem_wb.sv
`timescale 1ns/1ps

module thumb_mem_wb (
	input  logic                      clk,
	input  logic                      mem_en,
	input  logic                      wb_en,
	input  thumb_core_pkg::word_t     result,
	input  thumb_core_pkg::word_t     store_data,
	input  thumb_isa_pkg::reg_idx_t   rd,
	input  logic                      reg_we,
	input  logic                      mem_store,
	input  logic                      mem_load,
	input  thumb_core_pkg::mem_size_e size,
	output thumb_core_pkg::addr_t     mem_addr,
	output thumb_core_pkg::word_t     mem_wdata,
	output thumb_core_pkg::mem_size_e mem_size,
	output logic                      mem_we,
	input  thumb_core_pkg::word_t     mem_rdata,
	output thumb_isa_pkg::reg_idx_t   wr_idx,
	output thumb_core_pkg::word_t     wr_data,
	output logic                      wr_en
);

	thumb_core_pkg::word_t   load_val;
	thumb_core_pkg::wb_sel_e wb_sel;
	thumb_core_pkg::word_t   wb_q;

	// ALU result doubles as the byte address
	assign mem_addr  = result;
	assign mem_wdata = store_data;
	assign mem_size  = size;
	assign mem_we    = mem_en & mem_store; // Single cycle store strobe

	// Lane pick from the aligned read word, always zero-extended
	always_comb begin
		case (size)
			thumb_core_pkg::SIZE_BYTE:
				load_val = thumb_core_pkg::word_t'(mem_rdata[{result[1:0], 3'b000} +: 8]);
			thumb_core_pkg::SIZE_HALF:
				load_val = thumb_core_pkg::word_t'(mem_rdata[{result[1], 4'b0000} +: 16]);
			default:
				load_val = mem_rdata;
		endcase
	end

	assign wb_sel = mem_load ? thumb_core_pkg::WB_MEM : thumb_core_pkg::WB_ALU;

	// MEM to WB register
	always_ff @(posedge clk) begin
		if (mem_en) begin
			wb_q <= (wb_sel == thumb_core_pkg::WB_MEM) ? load_val : result;
		end
	end

	// rd stays valid from decode until the next decode
	assign wr_idx  = rd;
	assign wr_data = wb_q;
	assign wr_en   = wb_en & reg_we;

endmodule

//--- thumb_regfile.sv
`timescale 1ns/1ps
`include "thumb_config.svh"

module thumb_regfile (
	input  logic                    clk,
	input  thumb_isa_pkg::reg_idx_t rs_a,
	input  thumb_isa_pkg::reg_idx_t rs_b,
	output thumb_core_pkg::word_t   rd_a,
	output thumb_core_pkg::word_t   rd_b,
	input  thumb_isa_pkg::reg_idx_t wr_idx,
	input  thumb_core_pkg::word_t   wr_data,
	input  logic                    wr_en
);

	thumb_core_pkg::word_t regs [`THUMB_NREGS];

	// Both reads are combinational
	assign rd_a = regs[rs_a];
	assign rd_b = regs[rs_b];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule
